/* Makefile */
TOP = tb_tag_cmp

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* src.f */
verilog/tag_cmp_pkg.sv
verilog/secded_enc.sv
verilog/secded_dec.sv
verilog/access_sequencer.sv
verilog/line_ecc_path.sv
verilog/way_hit_cmp.sv
verilog/tag_cmp.sv
tb/tb_tag_cmp.sv

/* tb/tb_tag_cmp.sv */
// Tag compare testbench
`timescale 1ns/10ps

module tb_tag_cmp
  import tag_cmp_pkg::*;
();

  localparam int unsigned NR_PORTS     = 2;
  localparam int unsigned NR_WAYS      = 4;
  localparam int unsigned DEPTH        = 1 << INDEX_WIDTH;
  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned N_FULL       = 24;
  localparam int unsigned N_PART       = 24;
  localparam int unsigned N_SINGLE     = 8;
  localparam int unsigned N_DOUBLE     = 4;
  localparam int unsigned N_HIT        = 8;
  localparam int unsigned N_DUAL       = 4;
  // one access is at most two grant cycles and one idle cycle
  localparam int unsigned OP_CYCLES    = 3;
  localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 2 + OP_CYCLES *
    (2 * (N_FULL + N_PART + N_SINGLE + N_DOUBLE + N_DUAL) + 3 * N_HIT);
  localparam int unsigned MAX_CYCLES   = 2 * TEST_CYCLES;

  logic                                       clk_i;
  logic                                       rst_ni;
  logic       [NR_PORTS-1:0][NR_WAYS-1:0]     req_i;
  logic       [NR_PORTS-1:0][INDEX_WIDTH-1:0] addr_i;
  logic       [NR_PORTS-1:0]                  we_i;
  line_t      [NR_PORTS-1:0]                  wdata_i;
  line_be_t   [NR_PORTS-1:0]                  be_i;
  logic       [NR_PORTS-1:0]                  gnt_o;
  logic       [NR_PORTS-1:0][TAG_WIDTH-1:0]   tag_i;
  line_t      [NR_WAYS-1:0]                   rdata_o;
  logic       [NR_WAYS-1:0]                   hit_way_o;
  err_t                                       err_o;
  logic       [NR_WAYS-1:0]                   sram_req_o;
  logic                                       sram_we_o;
  logic       [INDEX_WIDTH-1:0]               sram_addr_o;
  sram_be_t                                   sram_be_o;
  line_code_t                                 sram_wdata_o;
  line_code_t [NR_WAYS-1:0]                   sram_rdata_i;

  line_code_t  mem       [NR_WAYS][DEPTH];
  line_code_t  flip_mask [NR_WAYS][DEPTH];
  line_t       model     [NR_WAYS][DEPTH];
  integer      seed;
  int unsigned value_errors;
  int unsigned other_errors;
  int unsigned cycle_count = 0;

  tag_cmp #(
    .NR_PORTS (NR_PORTS),
    .NR_WAYS  (NR_WAYS)
  ) u_dut (
    .clk_i, .rst_ni, .req_i, .addr_i, .we_i, .wdata_i, .be_i, .gnt_o, .tag_i,
    .rdata_o, .hit_way_o, .err_o, .sram_req_o, .sram_we_o, .sram_addr_o,
    .sram_be_o, .sram_wdata_o, .sram_rdata_i
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("run stopped, cycle limit of %0d reached before the tests ended", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // SRAM model, read data one cycle after the request
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int unsigned w = 0; w < NR_WAYS; w++) begin
        for (int unsigned i = 0; i < DEPTH; i++) begin
          mem[w][i] <= '0;
        end
      end
      sram_rdata_i <= '0;
    end else begin
      for (int unsigned w = 0; w < NR_WAYS; w++) begin
        if (sram_req_o[w] && sram_we_o) begin
          if (sram_be_o.valid) begin
            mem[w][sram_addr_o].valid <= sram_wdata_o.valid;
          end
          if (sram_be_o.tag) begin
            mem[w][sram_addr_o].tag <= sram_wdata_o.tag;
          end
          for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
            if (sram_be_o.data[b]) begin
              mem[w][sram_addr_o].data[b] <= sram_wdata_o.data[b];
            end
          end
        end else if (sram_req_o[w]) begin
          // injected upsets show up on the read port
          sram_rdata_i[w] <= mem[w][sram_addr_o] ^ flip_mask[w][sram_addr_o];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // random stimulus and reference model
  // ------------------------------------------------------------
  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic line_t random_line();
    logic [95:0] bits;
    bits = {$random(seed), $random(seed), $random(seed)};
    return bits[$bits(line_t)-1:0];
  endfunction

  function automatic logic [NR_WAYS-1:0] way_mask(input int unsigned way);
    logic [NR_WAYS-1:0] mask;
    mask      = '0;
    mask[way] = 1'b1;
    return mask;
  endfunction

  // every block either fully enabled or fully disabled
  function automatic line_be_t full_block_be();
    line_be_t be;
    be.tag = rand_below(2) == 1;
    for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
      be.data[b*BLOCK_BYTES +: BLOCK_BYTES] = {BLOCK_BYTES{rand_below(2) == 1}};
    end
    return be;
  endfunction

  function automatic line_be_t partial_be();
    line_be_t    be;
    int unsigned b;
    be.tag = rand_below(2) == 1;
    for (int unsigned k = 0; k < DATA_BLOCKS * BLOCK_BYTES; k++) begin
      be.data[k] = rand_below(2) == 1;
    end
    // at least one block keeps a single byte enabled
    b = rand_below(DATA_BLOCKS);
    be.data[b*BLOCK_BYTES +: BLOCK_BYTES] = '0;
    be.data[b*BLOCK_BYTES + rand_below(BLOCK_BYTES)] = 1'b1;
    return be;
  endfunction

  function automatic line_t apply_write(input line_t old, input line_t line,
                                        input line_be_t be);
    line_t res;
    res = old;
    if (be.tag) begin
      res.valid = line.valid;
      res.tag   = line.tag;
    end
    for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
      for (int unsigned k = 0; k < BLOCK_BYTES; k++) begin
        if (be.data[b*BLOCK_BYTES+k]) begin
          res.data[b][k*8 +: 8] = line.data[b][k*8 +: 8];
        end
      end
    end
    return res;
  endfunction

  task automatic flip_tag_bit(input int unsigned way, input int unsigned idx,
                              input int unsigned pos);
    flip_mask[way][idx].tag[pos] = ~flip_mask[way][idx].tag[pos];
  endtask

  task automatic flip_data_bit(input int unsigned way, input int unsigned idx,
                               input int unsigned blk, input int unsigned pos);
    flip_mask[way][idx].data[blk][pos] = ~flip_mask[way][idx].data[blk][pos];
  endtask

  // ------------------------------------------------------------
  // access tasks and checks
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("Fail %0t: %s got %0h expected %0h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // ends on the falling edge after the grant, request dropped
  task automatic issue(input int unsigned port, input logic [NR_WAYS-1:0] ways,
                       input int unsigned idx, input logic we, input line_t line,
                       input line_be_t be, input int unsigned exp_cycles);
    int unsigned cycles;
    @(negedge clk_i);
    req_i[port]   = ways;
    addr_i[port]  = INDEX_WIDTH'(idx);
    we_i[port]    = we;
    wdata_i[port] = line;
    be_i[port]    = be;
    cycles        = 1;
    #(CLK_PERIOD / 4);
    while (!gnt_o[port] && cycles < 4) begin
      @(negedge clk_i);
      cycles++;
      #(CLK_PERIOD / 4);
    end
    assert (gnt_o[port]) else begin
      $display("port %0d was not granted within %0d cycles", port, cycles);
      other_errors++;
    end
    check_value("grant latency", 128'(cycles), 128'(exp_cycles));
    @(negedge clk_i);
    req_i[port] = '0;
    we_i[port]  = 1'b0;
  endtask

  task automatic write_line(input int unsigned port, input int unsigned way,
                            input int unsigned idx, input line_t line,
                            input line_be_t be, input int unsigned exp_cycles);
    issue(port, way_mask(way), idx, 1'b1, line, be, exp_cycles);
    model[way][idx] = apply_write(model[way][idx], line, be);
  endtask

  task automatic check_results(input int unsigned idx, input logic [TAG_WIDTH-1:0] tag,
                               input logic exp_corr, input logic exp_uncorr);
    logic hit;
    #(CLK_PERIOD / 4);
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      hit = model[w][idx].valid && (model[w][idx].tag == tag);
      if (!exp_uncorr) begin
        check_value($sformatf("rdata_o[%0d]", w), 128'(rdata_o[w]), 128'(model[w][idx]));
      end
      check_value($sformatf("hit_way_o[%0d]", w), 128'(hit_way_o[w]), 128'(hit));
    end
    check_value("err_o.corr", 128'(err_o.corr), 128'(exp_corr));
    check_value("err_o.uncorr", 128'(err_o.uncorr), 128'(exp_uncorr));
  endtask

  // reads all ways, tag follows one cycle behind the request
  task automatic read_and_check(input int unsigned port, input int unsigned idx,
                                input logic [TAG_WIDTH-1:0] tag, input logic exp_corr,
                                input logic exp_uncorr);
    issue(port, '1, idx, 1'b0, '0, '0, 1);
    tag_i[port] = tag;
    check_results(idx, tag, exp_corr, exp_uncorr);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    int unsigned          port;
    int unsigned          way;
    int unsigned          idx;
    int unsigned          blk;
    int unsigned          b1;
    int unsigned          b2;
    line_t                line;
    line_be_t             be;
    logic [TAG_WIDTH-1:0] tag;
    seed         = 32'h1cf5;
    value_errors = 0;
    other_errors = 0;
    rst_ni       = 1'b0;
    req_i        = '0;
    addr_i       = '0;
    we_i         = '0;
    wdata_i      = '0;
    be_i         = '0;
    tag_i        = '0;
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        flip_mask[w][i] = '0;
        model[w][i]     = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // direct writes then reads
    for (int unsigned n = 0; n < N_FULL; n++) begin
      port = rand_below(NR_PORTS);
      way  = rand_below(NR_WAYS);
      idx  = rand_below(DEPTH);
      write_line(port, way, idx, random_line(), full_block_be(), 1);
      read_and_check(port, idx, model[way][idx].tag, 1'b0, 1'b0);
    end

    // partial writes go through read-modify-write
    for (int unsigned n = 0; n < N_PART; n++) begin
      port = rand_below(NR_PORTS);
      way  = rand_below(NR_WAYS);
      idx  = rand_below(DEPTH);
      write_line(port, way, idx, random_line(), partial_be(), 2);
      read_and_check(port, idx, model[way][idx].tag, 1'b0, 1'b0);
    end

    // single upsets in tag or data
    for (int unsigned n = 0; n < N_SINGLE; n++) begin
      way        = rand_below(NR_WAYS);
      idx        = rand_below(DEPTH);
      line       = random_line();
      line.valid = 1'b1;
      write_line(0, way, idx, line, '1, 1);
      if (n % 2 == 0) begin
        flip_tag_bit(way, idx, rand_below(TAG_CODE_WIDTH));
      end else begin
        flip_data_bit(way, idx, rand_below(DATA_BLOCKS), rand_below(BLOCK_CODE_WIDTH));
      end
      read_and_check(0, idx, line.tag, 1'b1, 1'b0);
      flip_mask[way][idx] = '0;
    end

    // double upsets in one block
    for (int unsigned n = 0; n < N_DOUBLE; n++) begin
      way        = rand_below(NR_WAYS);
      idx        = rand_below(DEPTH);
      line       = random_line();
      line.valid = 1'b1;
      write_line(0, way, idx, line, '1, 1);
      blk = rand_below(DATA_BLOCKS);
      b1  = rand_below(BLOCK_CODE_WIDTH);
      b2  = (b1 + 1 + rand_below(BLOCK_CODE_WIDTH - 1)) % BLOCK_CODE_WIDTH;
      flip_data_bit(way, idx, blk, b1);
      flip_data_bit(way, idx, blk, b2);
      read_and_check(0, idx, line.tag, 1'b0, 1'b1);
      flip_mask[way][idx] = '0;
    end

    // hit compare, before and after a tag upset
    for (int unsigned n = 0; n < N_HIT; n++) begin
      port       = n % NR_PORTS;
      way        = rand_below(NR_WAYS);
      idx        = rand_below(DEPTH);
      line       = random_line();
      line.valid = 1'b1;
      write_line(port, way, idx, line, '1, 1);
      tag = (rand_below(2) == 1) ? line.tag : TAG_WIDTH'(rand_below(1 << TAG_WIDTH));
      read_and_check(port, idx, tag, 1'b0, 1'b0);
      flip_tag_bit(way, idx, rand_below(TAG_CODE_WIDTH));
      read_and_check(port, idx, tag, 1'b1, 1'b0);
      flip_mask[way][idx] = '0;
    end

    // port 0 writes while port 1 waits to read the same set
    for (int unsigned n = 0; n < N_DUAL; n++) begin
      way  = rand_below(NR_WAYS);
      idx  = rand_below(DEPTH);
      line = random_line();
      be   = full_block_be();
      @(negedge clk_i);
      req_i[0]   = way_mask(way);
      addr_i[0]  = INDEX_WIDTH'(idx);
      we_i[0]    = 1'b1;
      wdata_i[0] = line;
      be_i[0]    = be;
      req_i[1]   = '1;
      addr_i[1]  = INDEX_WIDTH'(idx);
      we_i[1]    = 1'b0;
      #(CLK_PERIOD / 4);
      check_value("gnt_o", 128'(gnt_o), 128'(1));
      model[way][idx] = apply_write(model[way][idx], line, be);
      @(negedge clk_i);
      req_i[0] = '0;
      we_i[0]  = 1'b0;
      #(CLK_PERIOD / 4);
      check_value("gnt_o", 128'(gnt_o), 128'(2));
      @(negedge clk_i);
      req_i[1] = '0;
      tag_i[1] = model[way][idx].tag;
      check_results(idx, model[way][idx].tag, 1'b0, 1'b0);
    end

    @(negedge clk_i);
    $display("closing count: %0d value mismatches, %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verilog/access_sequencer.sv */
// Cache access sequencer
`timescale 1ns/10ps

module access_sequencer
  import tag_cmp_pkg::*;
#(
  parameter int unsigned NR_PORTS = 2,
  parameter int unsigned NR_WAYS  = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic     [NR_PORTS-1:0][NR_WAYS-1:0]     req_i,
  input  logic     [NR_PORTS-1:0][INDEX_WIDTH-1:0] addr_i,
  input  logic     [NR_PORTS-1:0]                 we_i,
  input  line_t    [NR_PORTS-1:0]                 wdata_i,
  input  line_be_t [NR_PORTS-1:0]                 be_i,
  output logic     [NR_PORTS-1:0]                 gnt_o,
  output logic     [NR_WAYS-1:0]                  sram_req_o,
  output logic                                    sram_we_o,
  output logic     [INDEX_WIDTH-1:0]              sram_addr_o,
  output sram_be_t                                sram_be_o,
  output line_t                                   wr_line_o,
  output line_be_t                                wr_be_o,
  output logic                                    merge_o,
  output logic     [NR_PORTS-1:0]                 port_id_o
);

  store_state_e             state_d, state_q;
  logic [NR_PORTS-1:0]      id_d, id_q;
  logic [NR_WAYS-1:0]       req_d, req_q;
  logic [INDEX_WIDTH-1:0]   addr_d, addr_q;
  line_be_t                 be_d, be_q;
  line_t                    line_d, line_q;

  // blocks whose bytes are all enabled
  function automatic logic [DATA_BLOCKS-1:0] full_blocks(input line_be_t be);
    logic [DATA_BLOCKS-1:0] full;
    for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
      full[b] = &be.data[b*BLOCK_BYTES +: BLOCK_BYTES];
    end
    return full;
  endfunction

  // any block with only some of its bytes enabled
  function automatic logic partial_write(input line_be_t be);
    logic partial;
    partial = 1'b0;
    for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
      partial |= (|be.data[b*BLOCK_BYTES +: BLOCK_BYTES]) &&
                 !(&be.data[b*BLOCK_BYTES +: BLOCK_BYTES]);
    end
    return partial;
  endfunction

  // ------------------------------------------------------------
  // fixed priority grant and write sequencing
  // ------------------------------------------------------------
  always_comb begin
    logic found;
    found       = 1'b0;
    state_d     = state_q;
    id_d        = id_q;
    req_d       = req_q;
    addr_d      = addr_q;
    be_d        = be_q;
    line_d      = line_q;
    gnt_o       = '0;
    sram_req_o  = '0;
    sram_we_o   = 1'b0;
    sram_addr_o = '0;
    sram_be_o   = '0;
    wr_line_o   = '0;
    wr_be_o     = '0;
    merge_o     = 1'b0;
    if (state_q == NORMAL) begin
      for (int unsigned i = 0; i < NR_PORTS; i++) begin
        if (!found && (|req_i[i])) begin
          found       = 1'b1;
          id_d        = '0;
          id_d[i]     = 1'b1;
          sram_req_o  = req_i[i];
          sram_addr_o = addr_i[i];
          wr_line_o   = wdata_i[i];
          wr_be_o     = be_i[i];
          if (we_i[i] && partial_write(be_i[i])) begin
            // read the old line first, grant on the write-back
            state_d = LOAD_AND_STORE;
            req_d   = req_i[i];
            addr_d  = addr_i[i];
            be_d    = be_i[i];
            line_d  = wdata_i[i];
          end else begin
            gnt_o[i]        = 1'b1;
            sram_we_o       = we_i[i];
            sram_be_o.valid = be_i[i].tag;
            sram_be_o.tag   = be_i[i].tag;
            sram_be_o.data  = full_blocks(be_i[i]);
          end
        end
      end
    end else begin
      // merged line goes back as a whole
      state_d     = NORMAL;
      gnt_o       = id_q;
      sram_req_o  = req_q;
      sram_we_o   = 1'b1;
      sram_addr_o = addr_q;
      sram_be_o   = '{valid: 1'b1, tag: 1'b1, data: '1};
      wr_line_o   = line_q;
      wr_be_o     = be_q;
      merge_o     = 1'b1;
    end
  end

  assign port_id_o = id_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= NORMAL;
      id_q    <= '0;
      req_q   <= '0;
      addr_q  <= '0;
      be_q    <= '0;
      line_q  <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
      req_q   <= req_d;
      addr_q  <= addr_d;
      be_q    <= be_d;
      line_q  <= line_d;
    end
  end

endmodule

/* verilog/line_ecc_path.sv */
// Line ECC encode and decode path
`timescale 1ns/10ps

module line_ecc_path
  import tag_cmp_pkg::*;
#(
  parameter int unsigned NR_WAYS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  line_t                    wr_line_i,
  input  line_be_t                 wr_be_i,
  input  logic                     merge_i,
  input  logic       [NR_WAYS-1:0] sram_req_i,
  input  line_code_t [NR_WAYS-1:0] sram_rdata_i,
  output line_code_t               sram_wdata_o,
  output line_t      [NR_WAYS-1:0] rdata_o,
  output err_t                     err_o
);

  logic [NR_WAYS-1:0]                  req_q;
  logic [NR_WAYS-1:0]                  tag_corr, tag_uncorr;
  logic [NR_WAYS-1:0][DATA_BLOCKS-1:0] blk_corr, blk_uncorr;
  line_t                               old_line;
  line_t                               store_line;

  // ways read last cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= '0;
    end else begin
      req_q <= sram_req_i;
    end
  end

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
    assign rdata_o[w].valid = sram_rdata_i[w].valid;

    secded_dec #(.DATA_WIDTH(TAG_WIDTH)) u_tag_dec (
      .code_i   (sram_rdata_i[w].tag),
      .data_o   (rdata_o[w].tag),
      .corr_o   (tag_corr[w]),
      .uncorr_o (tag_uncorr[w])
    );

    for (genvar b = 0; b < DATA_BLOCKS; b++) begin : g_blk
      secded_dec #(.DATA_WIDTH(BLOCK_WIDTH)) u_blk_dec (
        .code_i   (sram_rdata_i[w].data[b]),
        .data_o   (rdata_o[w].data[b]),
        .corr_o   (blk_corr[w][b]),
        .uncorr_o (blk_uncorr[w][b])
      );
    end
  end

  // only valid lines of requested ways count
  always_comb begin
    err_o = '0;
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      if (req_q[w] && sram_rdata_i[w].valid) begin
        err_o.corr   = err_o.corr | tag_corr[w] | (|blk_corr[w]);
        err_o.uncorr = err_o.uncorr | tag_uncorr[w] | (|blk_uncorr[w]);
      end
    end
  end

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------
  // corrected line of the first way read
  always_comb begin
    logic found;
    found    = 1'b0;
    old_line = '0;
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      if (!found && req_q[w]) begin
        found    = 1'b1;
        old_line = rdata_o[w];
      end
    end
  end

  always_comb begin
    store_line = wr_line_i;
    if (merge_i) begin
      store_line.valid = wr_be_i.tag ? wr_line_i.valid : old_line.valid;
      store_line.tag   = wr_be_i.tag ? wr_line_i.tag : old_line.tag;
      for (int unsigned b = 0; b < DATA_BLOCKS; b++) begin
        for (int unsigned k = 0; k < BLOCK_BYTES; k++) begin
          if (!wr_be_i.data[b*BLOCK_BYTES+k]) begin
            store_line.data[b][k*8 +: 8] = old_line.data[b][k*8 +: 8];
          end
        end
      end
    end
  end

  assign sram_wdata_o.valid = store_line.valid;

  secded_enc #(.DATA_WIDTH(TAG_WIDTH)) u_tag_enc (
    .data_i (store_line.tag),
    .code_o (sram_wdata_o.tag)
  );

  for (genvar b = 0; b < DATA_BLOCKS; b++) begin : g_enc
    secded_enc #(.DATA_WIDTH(BLOCK_WIDTH)) u_blk_enc (
      .data_i (store_line.data[b]),
      .code_o (sram_wdata_o.data[b])
    );
  end

endmodule

/* verilog/secded_dec.sv */
// SECDED Hamming decoder
`timescale 1ns/10ps

module secded_dec
  import tag_cmp_pkg::*;
#(
  parameter  int unsigned DATA_WIDTH = 16,
  localparam int unsigned CHECK_BITS = secded_check_bits(DATA_WIDTH),
  localparam int unsigned CODE_WIDTH = DATA_WIDTH + CHECK_BITS + 1
) (
  input  logic [CODE_WIDTH-1:0] code_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  corr_o,
  output logic                  uncorr_o
);

  logic [CHECK_BITS-1:0] syndrome;
  logic                  parity_odd;

  // ------------------------------------------------------------
  // syndrome and overall parity
  // ------------------------------------------------------------
  always_comb begin
    syndrome = '0;
    for (int unsigned p = 0; p < CHECK_BITS; p++) begin
      for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
        if (((pos >> p) & 1) != 0) begin
          syndrome[p] ^= code_i[pos];
        end
      end
    end
  end

  assign parity_odd = ^code_i;

  // odd parity means one flipped bit, possibly the parity bit itself
  assign corr_o   = parity_odd;
  assign uncorr_o = !parity_odd && (syndrome != '0);

  // ------------------------------------------------------------
  // correction and data extraction
  // ------------------------------------------------------------
  always_comb begin
    logic [CODE_WIDTH-1:0] code;
    int unsigned           d;
    code = code_i;
    d    = 0;
    if (parity_odd && (syndrome != '0)) begin
      for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
        if (syndrome == CHECK_BITS'(pos)) begin
          code[pos] = ~code[pos];
        end
      end
    end
    data_o = '0;
    for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data_o[d] = code[pos];
        d++;
      end
    end
  end

endmodule

/* verilog/secded_enc.sv */
// SECDED Hamming encoder
`timescale 1ns/10ps

module secded_enc
  import tag_cmp_pkg::*;
#(
  parameter  int unsigned DATA_WIDTH = 16,
  localparam int unsigned CHECK_BITS = secded_check_bits(DATA_WIDTH),
  localparam int unsigned CODE_WIDTH = DATA_WIDTH + CHECK_BITS + 1
) (
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [CODE_WIDTH-1:0] code_o
);

  // bit 0 is the overall parity, bits 1 and up are Hamming positions
  always_comb begin
    logic [CODE_WIDTH-1:0] code;
    logic                  parity;
    int unsigned           d;
    code = '0;
    d    = 0;
    // data fills every position that is not a power of two
    for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        code[pos] = data_i[d];
        d++;
      end
    end
    // check bit p covers the positions with index bit p set
    for (int unsigned p = 0; p < CHECK_BITS; p++) begin
      parity = 1'b0;
      for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
        if (((pos >> p) & 1) != 0) begin
          parity ^= code[pos];
        end
      end
      code[1 << p] = parity;
    end
    code[0] = ^code[CODE_WIDTH-1:1];
    code_o  = code;
  end

endmodule

/* verilog/tag_cmp.sv */
// Protected tag compare top level
`timescale 1ns/10ps

module tag_cmp
  import tag_cmp_pkg::*;
#(
  parameter int unsigned NR_PORTS = 2,
  parameter int unsigned NR_WAYS  = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic       [NR_PORTS-1:0][NR_WAYS-1:0]     req_i,
  input  logic       [NR_PORTS-1:0][INDEX_WIDTH-1:0] addr_i,
  input  logic       [NR_PORTS-1:0]               we_i,
  input  line_t      [NR_PORTS-1:0]               wdata_i,
  input  line_be_t   [NR_PORTS-1:0]               be_i,
  output logic       [NR_PORTS-1:0]               gnt_o,
  input  logic       [NR_PORTS-1:0][TAG_WIDTH-1:0]   tag_i,
  output line_t      [NR_WAYS-1:0]                rdata_o,
  output logic       [NR_WAYS-1:0]                hit_way_o,
  output err_t                                    err_o,
  output logic       [NR_WAYS-1:0]                sram_req_o,
  output logic                                    sram_we_o,
  output logic       [INDEX_WIDTH-1:0]            sram_addr_o,
  output sram_be_t                                sram_be_o,
  output line_code_t                              sram_wdata_o,
  input  line_code_t [NR_WAYS-1:0]                sram_rdata_i
);

  line_t               wr_line;
  line_be_t            wr_be;
  logic                merge;
  logic [NR_PORTS-1:0] port_id;

  access_sequencer #(.NR_PORTS(NR_PORTS), .NR_WAYS(NR_WAYS)) u_seq (
    .clk_i, .rst_ni, .req_i, .addr_i, .we_i, .wdata_i, .be_i, .gnt_o,
    .sram_req_o, .sram_we_o, .sram_addr_o, .sram_be_o,
    .wr_line_o (wr_line),
    .wr_be_o   (wr_be),
    .merge_o   (merge),
    .port_id_o (port_id)
  );

  line_ecc_path #(.NR_WAYS(NR_WAYS)) u_ecc (
    .clk_i, .rst_ni,
    .wr_line_i  (wr_line),
    .wr_be_i    (wr_be),
    .merge_i    (merge),
    .sram_req_i (sram_req_o),
    .sram_rdata_i, .sram_wdata_o, .rdata_o, .err_o
  );

  way_hit_cmp #(.NR_PORTS(NR_PORTS), .NR_WAYS(NR_WAYS)) u_hit (
    .clk_i, .rst_ni,
    .port_id_i (port_id),
    .tag_i, .sram_rdata_i, .hit_way_o
  );

endmodule

/* verilog/tag_cmp_pkg.sv */
// Tag compare definitions
package tag_cmp_pkg;

  // ------------------------------------------------------------
  // SECDED sizing
  // ------------------------------------------------------------
  // smallest number of Hamming check bits that covers data_width
  function automatic int unsigned secded_check_bits(input int unsigned data_width);
    int unsigned p;
    p = 1;
    while ((32'd1 << p) < data_width + p + 1) begin
      p++;
    end
    return p;
  endfunction

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int unsigned INDEX_WIDTH      = 4;
  localparam int unsigned TAG_WIDTH        = 12;
  // Hamming bits plus one overall parity bit
  localparam int unsigned TAG_CODE_WIDTH   = TAG_WIDTH + secded_check_bits(TAG_WIDTH) + 1;
  localparam int unsigned BLOCK_WIDTH      = 16;
  localparam int unsigned BLOCK_BYTES      = BLOCK_WIDTH / 8;
  localparam int unsigned BLOCK_CODE_WIDTH = BLOCK_WIDTH + secded_check_bits(BLOCK_WIDTH) + 1;
  localparam int unsigned DATA_BLOCKS      = 4;

  // ------------------------------------------------------------
  // line and enable types
  // ------------------------------------------------------------
  typedef struct packed {
    logic                                    valid;
    logic [TAG_WIDTH-1:0]                    tag;
    logic [DATA_BLOCKS-1:0][BLOCK_WIDTH-1:0] data;
  } line_t;

  // line as held in the SRAM
  typedef struct packed {
    logic                                         valid;
    logic [TAG_CODE_WIDTH-1:0]                    tag;
    logic [DATA_BLOCKS-1:0][BLOCK_CODE_WIDTH-1:0] data;
  } line_code_t;

  typedef struct packed {
    logic                               tag;
    logic [DATA_BLOCKS*BLOCK_BYTES-1:0] data;
  } line_be_t;

  // one enable per protected block
  typedef struct packed {
    logic                   valid;
    logic                   tag;
    logic [DATA_BLOCKS-1:0] data;
  } sram_be_t;

  typedef struct packed {
    logic corr;
    logic uncorr;
  } err_t;

  typedef enum logic {
    NORMAL,
    LOAD_AND_STORE
  } store_state_e;

endpackage

/* verilog/way_hit_cmp.sv */
// Per way tag hit compare
`timescale 1ns/10ps

module way_hit_cmp
  import tag_cmp_pkg::*;
#(
  parameter int unsigned NR_PORTS = 2,
  parameter int unsigned NR_WAYS  = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic       [NR_PORTS-1:0]            port_id_i,
  input  logic       [NR_PORTS-1:0][TAG_WIDTH-1:0] tag_i,
  input  line_code_t [NR_WAYS-1:0]             sram_rdata_i,
  output logic       [NR_WAYS-1:0]             hit_way_o
);

  logic [NR_PORTS-1:0]                     id_q;
  logic [TAG_WIDTH-1:0]                    sel_tag;
  logic [TAG_CODE_WIDTH-1:0]               sel_code;
  logic [NR_WAYS-1:0][TAG_CODE_WIDTH-1:0]  diff;

  // tag arrives one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else begin
      id_q <= port_id_i;
    end
  end

  always_comb begin
    sel_tag = '0;
    for (int unsigned i = 0; i < NR_PORTS; i++) begin
      if (id_q[i]) begin
        sel_tag = tag_i[i];
      end
    end
  end

  secded_enc #(.DATA_WIDTH(TAG_WIDTH)) u_tag_enc (
    .data_i (sel_tag),
    .code_o (sel_code)
  );

  // hit tolerates one flipped bit in the stored codeword
  for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
    assign diff[w]      = sel_code ^ sram_rdata_i[w].tag;
    assign hit_way_o[w] = sram_rdata_i[w].valid && ((diff[w] & (diff[w] - 1'b1)) == '0);
  end

endmodule
